// File: src/vic_pkg.sv
package vic_pkg;

  // bus cycle shape, counted in 4x clocks
  localparam int unsigned ticks_per_cycle = 16;
  localparam int unsigned phi_high_tick   = 8;    // phi rises here

  // raster geometry of a PAL frame
  localparam int unsigned cycles_per_line = 63;
  localparam int unsigned lines_per_frame = 312;

  localparam int unsigned hsync_cycles = 4;       // cycles 0..3 carry hsync
  localparam int unsigned vsync_lines  = 3;       // lines 0..2 carry vsync

  // visible window, both bounds inclusive
  localparam int unsigned active_first_cycle = 16;
  localparam int unsigned active_last_cycle  = 55;
  localparam int unsigned active_first_line  = 51;
  localparam int unsigned active_last_line   = 250;

  // cpu register map, 6 bit offsets
  localparam logic [5:0] reg_ctrl       = 6'h11;  // bit 7 is raster bit 8
  localparam logic [5:0] reg_raster     = 6'h12;
  localparam logic [5:0] reg_irq_status = 6'h19;
  localparam logic [5:0] reg_irq_enable = 6'h1a;
  localparam logic [5:0] reg_border     = 6'h20;
  localparam logic [5:0] reg_background = 6'h21;

  // colour table packed as {red, green, blue}, 6 bits per channel
  localparam logic [17:0] palette [16] = '{
    {6'h00, 6'h00, 6'h00},  // black
    {6'h3f, 6'h3f, 6'h3f},  // white
    {6'h1a, 6'h0d, 6'h0a},  // red
    {6'h1c, 6'h29, 6'h2c},  // cyan
    {6'h1b, 6'h0f, 6'h21},  // purple
    {6'h16, 6'h23, 6'h10},  // green
    {6'h0d, 6'h0a, 6'h1e},  // blue
    {6'h2e, 6'h31, 6'h1b},  // yellow
    {6'h1b, 6'h13, 6'h09},  // orange
    {6'h10, 6'h0e, 6'h00},  // brown
    {6'h26, 6'h19, 6'h16},  // light red
    {6'h11, 6'h11, 6'h11},  // dark grey
    {6'h1b, 6'h1b, 6'h1b},  // mid grey
    {6'h26, 6'h34, 6'h21},  // light green
    {6'h1b, 6'h17, 6'h2d},  // light blue
    {6'h25, 6'h25, 6'h25}   // light grey
  };

  // one state per slice of the 16 tick bus cycle
  typedef enum logic [2:0] {
    ST_RESET,
    ST_VIC_ADDR,    // ticks 0-1, refresh address out
    ST_VIC_RAS,     // ticks 2-3
    ST_VIC_CAS,     // ticks 4-7
    ST_CPU_WAIT,    // ticks 8-11, cpu settles ce/rw/adl
    ST_CPU_ACCESS,  // tick 12
    ST_CPU_HOLD     // ticks 13-15
  } bus_state_t;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_READ,
    OP_WRITE
  } reg_op_t;

endpackage

// File: src/raster_timer.sv
`timescale 1ns/10ps

module raster_timer (
  input  logic       clk_col4x_pal,
  input  logic       rst_n,
  output logic [3:0] tick,        // position inside the bus cycle
  output logic [5:0] cycle,       // bus cycle inside the line
  output logic [8:0] line,        // raster line
  output logic       line_start,  // tick 0 of cycle 0
  output logic       hsync,
  output logic       vsync,
  output logic       active
);

  logic [3:0] tick_nxt;
  logic [5:0] cycle_nxt;
  logic [8:0] line_nxt;
  logic       h_active;
  logic       v_active;

  // nested counters, each one wraps and carries into the next
  always_comb begin
    tick_nxt  = tick + 4'd1;
    cycle_nxt = cycle;
    line_nxt  = line;
    if (tick == 4'(vic_pkg::ticks_per_cycle - 1)) begin
      tick_nxt  = 4'd0;
      cycle_nxt = cycle + 6'd1;
      if (cycle == 6'(vic_pkg::cycles_per_line - 1)) begin
        cycle_nxt = 6'd0;
        line_nxt  = line + 9'd1;
        if (line == 9'(vic_pkg::lines_per_frame - 1)) begin
          line_nxt = 9'd0;  // frame wrap
        end
      end
    end
  end

  // window decode taken from the next values so the flags line up
  // with the counters once registered
  assign h_active = (cycle_nxt >= 6'(vic_pkg::active_first_cycle)) &&
                    (cycle_nxt <= 6'(vic_pkg::active_last_cycle));
  assign v_active = (line_nxt >= 9'(vic_pkg::active_first_line)) &&
                    (line_nxt <= 9'(vic_pkg::active_last_line));

  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      tick       <= 4'd0;
      cycle      <= 6'd0;
      line       <= 9'd0;
      line_start <= 1'b1;  // counters sit at the origin during reset
      hsync      <= 1'b1;
      vsync      <= 1'b1;
      active     <= 1'b0;
    end else begin
      tick       <= tick_nxt;
      cycle      <= cycle_nxt;
      line       <= line_nxt;
      line_start <= (tick_nxt == 4'd0) && (cycle_nxt == 6'd0);
      hsync      <= cycle_nxt < 6'(vic_pkg::hsync_cycles);
      vsync      <= line_nxt < 9'(vic_pkg::vsync_lines);
      active     <= h_active && v_active;
    end
  end

endmodule

// File: src/bus_sequencer.sv
`timescale 1ns/10ps

module bus_sequencer (
  input  logic             clk_col4x_pal,
  input  logic             rst_n,
  input  logic [3:0]       tick,
  input  logic             ce,              // low selects the chip
  input  logic             rw,              // high is a cpu read
  input  logic [5:0]       adi,             // cpu register offset from adl
  output logic             clk_phi,
  output logic             ras,             // active low
  output logic             cas,             // active low
  output logic             rw_ctl,
  output logic             vic_write_ab,
  output logic             vic_write_db,
  output logic [11:0]      ado,
  output vic_pkg::reg_op_t reg_op,
  output logic [5:0]       reg_addr,
  output logic             ls245_addr_dir,
  output logic             ls245_data_dir
);

  vic_pkg::bus_state_t state;
  vic_pkg::bus_state_t state_nxt;
  logic [3:0]          tick_nxt;
  logic [7:0]          refresh;     // dram refresh row
  logic                ab_nxt;
  logic                db_nxt;

  assign tick_nxt = tick + 4'd1;  // wraps at 16 by width

  // state follows the tick that the timer is about to show
  always_comb begin
    case (tick_nxt) inside
      [4'd0:4'd1]:   state_nxt = vic_pkg::ST_VIC_ADDR;
      [4'd2:4'd3]:   state_nxt = vic_pkg::ST_VIC_RAS;
      [4'd4:4'd7]:   state_nxt = vic_pkg::ST_VIC_CAS;
      [4'd8:4'd11]:  state_nxt = vic_pkg::ST_CPU_WAIT;
      4'd12:         state_nxt = vic_pkg::ST_CPU_ACCESS;
      [4'd13:4'd15]: state_nxt = vic_pkg::ST_CPU_HOLD;
      default:       state_nxt = vic_pkg::ST_RESET;
    endcase
  end

  // vic owns the address bus for the whole phi low half
  assign ab_nxt = (state_nxt == vic_pkg::ST_VIC_ADDR) ||
                  (state_nxt == vic_pkg::ST_VIC_RAS)  ||
                  (state_nxt == vic_pkg::ST_VIC_CAS);

  // read data goes out from the tick after the access to the end of phi
  assign db_nxt = (state_nxt == vic_pkg::ST_CPU_HOLD) &&
                  ((reg_op == vic_pkg::OP_READ) || vic_write_db);

  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      state          <= vic_pkg::ST_RESET;
      clk_phi        <= 1'b0;
      ras            <= 1'b1;
      cas            <= 1'b1;
      vic_write_ab   <= 1'b0;
      vic_write_db   <= 1'b0;
      rw_ctl         <= 1'b1;
      ls245_addr_dir <= 1'b0;
      ls245_data_dir <= 1'b0;
      refresh        <= 8'hff;
      reg_op         <= vic_pkg::OP_NONE;
    end else begin
      state          <= state_nxt;
      clk_phi        <= tick_nxt >= 4'(vic_pkg::phi_high_tick);
      ras            <= !((state_nxt == vic_pkg::ST_VIC_RAS) ||
                          (state_nxt == vic_pkg::ST_VIC_CAS));  // low ticks 2-7
      cas            <= state_nxt != vic_pkg::ST_VIC_CAS;       // low ticks 4-7
      vic_write_ab   <= ab_nxt;
      vic_write_db   <= db_nxt;
      rw_ctl         <= !db_nxt;  // only low while we drive dbl
      ls245_addr_dir <= ab_nxt;
      ls245_data_dir <= db_nxt;

      // step the refresh row as the dram access closes
      if (state == vic_pkg::ST_VIC_CAS && state_nxt == vic_pkg::ST_CPU_WAIT) begin
        refresh <= refresh - 8'd1;
      end

      // single clock opcode during tick 12
      if (state_nxt == vic_pkg::ST_CPU_ACCESS && !ce) begin
        reg_op <= rw ? vic_pkg::OP_READ : vic_pkg::OP_WRITE;
      end else begin
        reg_op <= vic_pkg::OP_NONE;
      end
    end
  end

  // address latch for the access, payload only
  always_ff @(posedge clk_col4x_pal) begin
    if (state_nxt == vic_pkg::ST_CPU_ACCESS) begin
      reg_addr <= adi;
    end
  end

  // high six lines float at 0x3f during refresh, row in the low six
  assign ado = {6'h3f, refresh[5:0]};

endmodule

// File: src/vic_registers.sv
`timescale 1ns/10ps

module vic_registers (
  input  logic             clk_col4x_pal,
  input  logic             rst_n,
  input  vic_pkg::reg_op_t reg_op,
  input  logic [5:0]       reg_addr,
  input  logic [7:0]       dbi,
  input  logic [8:0]       line,
  input  logic             line_start,
  output logic [7:0]       dbo,
  output logic             irq,               // active low
  output logic [3:0]       border_color,
  output logic [3:0]       background_color
);

  logic [6:0] ctrl_low;     // ctrl bits 6..0, stored but not decoded here
  logic [8:0] raster_cmp;   // raster compare, bit 8 lives in ctrl
  logic [3:0] irq_en;
  logic       irq_st;       // raster status, bit 0
  logic       irq_pending;
  logic       raster_hit;
  logic       wr;
  logic [7:0] rd_data;

  assign wr          = reg_op == vic_pkg::OP_WRITE;
  assign raster_hit  = line_start && (line == raster_cmp);
  assign irq_pending = irq_st && irq_en[0];

  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      ctrl_low         <= 7'd0;
      raster_cmp       <= 9'd0;
      irq_en           <= 4'd0;
      irq_st           <= 1'b0;
      border_color     <= 4'd0;
      background_color <= 4'd0;
      irq              <= 1'b1;
    end else begin
      if (wr) begin
        case (reg_addr)
          vic_pkg::reg_ctrl: begin
            ctrl_low      <= dbi[6:0];
            raster_cmp[8] <= dbi[7];
          end
          vic_pkg::reg_raster:     raster_cmp[7:0]  <= dbi;
          vic_pkg::reg_irq_enable: irq_en           <= dbi[3:0];
          vic_pkg::reg_border:     border_color     <= dbi[3:0];
          vic_pkg::reg_background: background_color <= dbi[3:0];
          default: ;  // status handled below, rest is unmapped
        endcase
      end

      // write one to clear, a match on the same edge wins
      if (raster_hit) begin
        irq_st <= 1'b1;
      end else if (wr && reg_addr == vic_pkg::reg_irq_status && dbi[0]) begin
        irq_st <= 1'b0;
      end

      irq <= !irq_pending;  // lags the status bit by one clock
    end
  end

  // read mux, line is live so raster reads show the current position
  always_comb begin
    case (reg_addr)
      vic_pkg::reg_ctrl:       rd_data = {line[8], ctrl_low};
      vic_pkg::reg_raster:     rd_data = line[7:0];
      vic_pkg::reg_irq_status: rd_data = {irq_pending, 6'd0, irq_st};
      vic_pkg::reg_irq_enable: rd_data = {4'hf, irq_en};
      vic_pkg::reg_border:     rd_data = {4'hf, border_color};
      vic_pkg::reg_background: rd_data = {4'hf, background_color};
      default:                 rd_data = 8'hff;
    endcase
  end

  // captured on the access tick, held on dbl through the end of phi
  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      dbo <= 8'd0;
    end else if (reg_op == vic_pkg::OP_READ) begin
      dbo <= rd_data;
    end
  end

endmodule

// File: src/pixel_out.sv
`timescale 1ns/10ps

module pixel_out (
  input  logic       clk_col4x_pal,
  input  logic       rst_n,
  input  logic       active,            // inside the display window
  input  logic [3:0] border_color,
  input  logic [3:0] background_color,
  output logic [5:0] red,
  output logic [5:0] green,
  output logic [5:0] blue
);

  logic [3:0]  color;
  logic [17:0] rgb;

  // no graphics fetch, so the window shows plain background
  assign color = active ? background_color : border_color;
  assign rgb   = vic_pkg::palette[color];

  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      red   <= 6'd0;
      green <= 6'd0;
      blue  <= 6'd0;
    end else begin
      red   <= rgb[17:12];
      green <= rgb[11:6];
      blue  <= rgb[5:0];
    end
  end

endmodule

// File: src/vic_top.sv
`timescale 1ns/10ps

module vic_top (
  input  logic           clk_col4x_pal,
  input  logic           rst_n,
  input  logic           ce,              // low selects the chip
  input  logic           rw,              // low is a cpu write
  input  logic           lp,              // light pen pin with no function yet
  inout  tri logic [5:0] adl,             // low address lines where the cpu puts the offset
  output tri logic [5:0] adh,             // high address lines
  inout  tri logic [7:0] dbl,             // data bus
  output logic           clk_phi,
  output logic           ras,
  output logic           cas,
  output logic           rw_ctl,
  output logic           irq,
  output logic           hsync,
  output logic           vsync,
  output logic           active,
  output logic [5:0]     red,
  output logic [5:0]     green,
  output logic [5:0]     blue,
  output logic           ls245_addr_dir,
  output logic           ls245_data_dir
);

  logic [3:0]       tick;
  logic [8:0]       line;
  logic             line_start;
  logic             vic_write_ab;
  logic             vic_write_db;
  logic [11:0]      ado;
  logic [7:0]       dbo;
  vic_pkg::reg_op_t reg_op;
  logic [5:0]       reg_addr;
  logic [3:0]       border_color;
  logic [3:0]       background_color;

  raster_timer i_raster_timer (
    .clk_col4x_pal (clk_col4x_pal),
    .rst_n         (rst_n),
    .tick          (tick),
    .cycle         (),
    .line          (line),
    .line_start    (line_start),
    .hsync         (hsync),
    .vsync         (vsync),
    .active        (active)
  );

  bus_sequencer i_bus_sequencer (
    .clk_col4x_pal  (clk_col4x_pal),
    .rst_n          (rst_n),
    .tick           (tick),
    .ce             (ce),
    .rw             (rw),
    .adi            (adl),
    .clk_phi        (clk_phi),
    .ras            (ras),
    .cas            (cas),
    .rw_ctl         (rw_ctl),
    .vic_write_ab   (vic_write_ab),
    .vic_write_db   (vic_write_db),
    .ado            (ado),
    .reg_op         (reg_op),
    .reg_addr       (reg_addr),
    .ls245_addr_dir (ls245_addr_dir),
    .ls245_data_dir (ls245_data_dir)
  );

  vic_registers i_vic_registers (
    .clk_col4x_pal    (clk_col4x_pal),
    .rst_n            (rst_n),
    .reg_op           (reg_op),
    .reg_addr         (reg_addr),
    .dbi              (dbl),
    .line             (line),
    .line_start       (line_start),
    .dbo              (dbo),
    .irq              (irq),
    .border_color     (border_color),
    .background_color (background_color)
  );

  pixel_out i_pixel_out (
    .clk_col4x_pal    (clk_col4x_pal),
    .rst_n            (rst_n),
    .active           (active),
    .border_color     (border_color),
    .background_color (background_color),
    .red              (red),
    .green            (green),
    .blue             (blue)
  );

  // drive the pins only while the sequencer owns them
  assign dbl = vic_write_db ? dbo : 8'bz;        // cpu read data
  assign adl = vic_write_ab ? ado[5:0] : 6'bz;   // refresh row
  assign adh = vic_write_ab ? ado[11:6] : 6'bz;

endmodule

// File: tests/tb_vic_top.sv
`timescale 1ns/10ps

module tb_vic_top;

  localparam int clocks_per_line = vic_pkg::ticks_per_cycle * vic_pkg::cycles_per_line;
  localparam int frame_clocks    = clocks_per_line * vic_pkg::lines_per_frame;

  // outputs that the wait loop can watch
  typedef enum {SIG_PHI, SIG_CAS, SIG_IRQ, SIG_ACTIVE, SIG_RW_CTL} watch_t;

  logic        clk_col4x_pal = 1'b0;
  logic        rst_n;
  logic        ce;
  logic        rw;
  logic        lp;
  logic [5:0]  adl_drv;          // cpu side of adl
  logic        adl_oe;
  logic [7:0]  dbl_drv;          // cpu write data
  logic        dbl_oe;
  tri   [5:0]  adl;
  tri   [5:0]  adh;
  tri   [7:0]  dbl;
  logic        clk_phi;
  logic        ras;
  logic        cas;
  logic        rw_ctl;
  logic        irq;
  logic        hsync;
  logic        vsync;
  logic        active;
  logic [5:0]  red;
  logic [5:0]  green;
  logic [5:0]  blue;
  logic        ls245_addr_dir;
  logic        ls245_data_dir;

  int          edge_cnt;         // clocks since reset release
  int          access_edges;     // edge count seen at the last access tick
  int          err_cnt   = 0;
  int          tests_ok  = 0;
  int          tests_bad = 0;
  logic [31:0] lcg_state = 32'hac26;

  always #5 clk_col4x_pal = ~clk_col4x_pal;  // 10 ns period

  always @(posedge clk_col4x_pal) begin
    if (!rst_n) edge_cnt <= 0;
    else edge_cnt <= edge_cnt + 1;
  end

  assign adl = adl_oe ? adl_drv : 6'bz;
  assign dbl = dbl_oe ? dbl_drv : 8'bz;  // only on during cpu writes

  vic_top i_vic_top (
    .clk_col4x_pal  (clk_col4x_pal),
    .rst_n          (rst_n),
    .ce             (ce),
    .rw             (rw),
    .lp             (lp),
    .adl            (adl),
    .adh            (adh),
    .dbl            (dbl),
    .clk_phi        (clk_phi),
    .ras            (ras),
    .cas            (cas),
    .rw_ctl         (rw_ctl),
    .irq            (irq),
    .hsync          (hsync),
    .vsync          (vsync),
    .active         (active),
    .red            (red),
    .green          (green),
    .blue           (blue),
    .ls245_addr_dir (ls245_addr_dir),
    .ls245_data_dir (ls245_data_dir)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [7:0] random_byte();
    logic [31:0] r;
    r = lcg_next();
    return r[23:16];  // upper bits since the low ones cycle fast
  endfunction

  // raster line for a clock count at 16 x 63 clocks per line
  function automatic int line_of(input int edges);
    return (edges / clocks_per_line) % vic_pkg::lines_per_frame;
  endfunction

  // bus cycle inside the line for a clock count
  function automatic int cycle_of(input int edges);
    return (edges / vic_pkg::ticks_per_cycle) % vic_pkg::cycles_per_line;
  endfunction

  // visible window for a clock count
  function automatic logic window_at(input int edges);
    int cyc;
    int ln;
    cyc = cycle_of(edges);
    ln  = line_of(edges);
    return cyc >= vic_pkg::active_first_cycle && cyc <= vic_pkg::active_last_cycle &&
           ln >= vic_pkg::active_first_line && ln <= vic_pkg::active_last_line;
  endfunction

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_rgb(input logic [5:0] r, input logic [5:0] g, input logic [5:0] b,
                           input logic [3:0] color, input string what);
    logic [17:0] exp;
    exp = vic_pkg::palette[color];
    if ({r, g, b} !== exp) begin
      $display("ERR %0t: %s is %h/%h/%h, expected colour %0d = %h/%h/%h", $time, what,
               r, g, b, color, exp[17:12], exp[11:6], exp[5:0]);
      err_cnt++;
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("run stopped at %0t: %s", $time, why);
    $display("test failed");
    $finish;
  endtask

  // sampled on the falling edge where every output is settled
  task automatic wait_level(input watch_t sig, input logic level, input int limit);
    logic cur;
    for (int i = 0; i < limit; i++) begin
      @(negedge clk_col4x_pal);
      case (sig)
        SIG_PHI:    cur = clk_phi;
        SIG_CAS:    cur = cas;
        SIG_IRQ:    cur = irq;
        SIG_ACTIVE: cur = active;
        default:    cur = rw_ctl;
      endcase
      if (cur === level) return;
    end
    abort_run($sformatf("%s never went to %b", sig.name(), level));
  endtask

  // one cpu cycle with the request placed in phi high and taken at tick 12
  task automatic cpu_access(input logic [5:0] addr, input logic write, input logic [7:0] wdata,
                            output logic [7:0] rdata);
    wait_level(SIG_PHI, 1'b0, 64);
    wait_level(SIG_PHI, 1'b1, 64);         // tick 8
    @(posedge clk_col4x_pal);
    ce      <= 1'b0;
    rw      <= !write;
    adl_drv <= addr;
    adl_oe  <= 1'b1;                        // vic left adl at tick 8
    dbl_drv <= wdata;
    dbl_oe  <= write;
    repeat (3) @(posedge clk_col4x_pal);    // ce and adl latched going into tick 12
    @(negedge clk_col4x_pal);
    access_edges = edge_cnt;
    @(posedge clk_col4x_pal);               // write data taken on this edge
    ce     <= 1'b1;
    rw     <= 1'b1;
    adl_oe <= 1'b0;
    dbl_oe <= 1'b0;
    rdata = 8'hxx;
    if (!write) begin
      wait_level(SIG_RW_CTL, 1'b0, 8);      // vic now drives dbl
      check_level(ls245_data_dir, 1'b1, "ls245_data_dir during read");
      rdata = dbl;
    end
  endtask

  task automatic cpu_write(input logic [5:0] addr, input logic [7:0] data);
    logic [7:0] ignored;
    cpu_access(addr, 1'b1, data, ignored);
  endtask

  task automatic cpu_read(input logic [5:0] addr, output logic [7:0] data);
    cpu_access(addr, 1'b0, 8'h00, data);
  endtask

  task automatic close_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      $display("[ok]   %s", name);
      tests_ok++;
    end else begin
      $display("[FAIL] %s, %0d mismatches", name, err_cnt - errs_before);
      tests_bad++;
    end
  endtask

  task automatic reset_state();
    int errs;
    errs = err_cnt;
    @(negedge clk_col4x_pal);               // still tick 0
    check_level(irq, 1'b1, "irq after reset");
    check_level(ras, 1'b1, "ras after reset");
    check_level(cas, 1'b1, "cas after reset");
    check_level(rw_ctl, 1'b1, "rw_ctl after reset");
    check_level(clk_phi, 1'b0, "clk_phi at tick 0");
    check_level(ls245_addr_dir, 1'b0, "ls245_addr_dir after reset");
    check_level(ls245_data_dir, 1'b0, "ls245_data_dir after reset");
    check_byte({2'bzz, adh}, 8'hzz, "adh after reset");
    check_byte({2'bzz, adl}, 8'hzz, "adl after reset");
    check_byte(dbl, 8'hzz, "dbl after reset");
    check_rgb(red, green, blue, 4'd0, "rgb after reset");
    close_test("reset state", errs);
  endtask

  task automatic refresh_cycles();
    int         errs;
    logic [7:0] row;
    errs = err_cnt;
    for (int k = 0; k < 8; k++) begin
      wait_level(SIG_CAS, 1'b0, 32);        // tick 4 in the middle of phi low
      row = 8'hff - 8'(edge_cnt / vic_pkg::ticks_per_cycle);
      check_byte({2'b00, adh}, 8'h3f, "refresh adh");
      check_byte({2'b00, adl}, {2'b00, row[5:0]}, "refresh row on adl");
      check_level(ras, 1'b0, "ras in phi low");
      check_level(cas, 1'b0, "cas in phi low");
      check_level(ls245_addr_dir, 1'b1, "ls245_addr_dir in phi low");
      // cycles 0..7 of line 0 cover both hsync levels
      check_level(hsync, cycle_of(edge_cnt) < vic_pkg::hsync_cycles, "hsync");
      check_level(vsync, line_of(edge_cnt) < vic_pkg::vsync_lines, "vsync");
      check_level(active, window_at(edge_cnt), "active outside window");
      wait_level(SIG_PHI, 1'b1, 32);
    end
    close_test("refresh cycles", errs);
  endtask

  task automatic register_readback();
    int         errs;
    logic [7:0] bord;
    logic [7:0] back;
    logic [7:0] data;
    errs = err_cnt;
    bord = random_byte();
    back = random_byte();
    cpu_write(vic_pkg::reg_border, bord);
    cpu_write(vic_pkg::reg_background, back);
    cpu_read(vic_pkg::reg_border, data);
    check_byte(data, {4'hf, bord[3:0]}, "border readback");
    cpu_read(vic_pkg::reg_background, data);
    check_byte(data, {4'hf, back[3:0]}, "background readback");
    cpu_read(6'h3f, data);
    check_byte(data, 8'hff, "unmapped 0x3f");
    cpu_read(6'h05, data);
    check_byte(data, 8'hff, "unmapped 0x05");
    close_test("register readback", errs);
  endtask

  task automatic raster_irq();
    int         errs;
    logic [7:0] data;
    logic [8:0] tgt;
    errs = err_cnt;
    cpu_write(vic_pkg::reg_irq_status, 8'h01);  // line 0 matched the reset compare value
    cpu_write(vic_pkg::reg_ctrl, 8'h00);
    cpu_write(vic_pkg::reg_raster, 8'h03);
    cpu_write(vic_pkg::reg_irq_enable, 8'h01);
    wait_level(SIG_IRQ, 1'b0, 2 * frame_clocks);
    check_byte(8'(line_of(edge_cnt)), 8'd3, "line when irq fell");
    cpu_read(vic_pkg::reg_irq_status, data);
    check_byte(data, 8'h81, "status with irq pending");
    cpu_write(vic_pkg::reg_irq_status, 8'h01);
    wait_level(SIG_IRQ, 1'b1, 16);
    cpu_read(vic_pkg::reg_irq_status, data);
    check_byte(data, 8'h00, "status after clear");
    // enable off and compare two lines ahead
    cpu_write(vic_pkg::reg_irq_enable, 8'h00);
    tgt = 9'((line_of(edge_cnt) + 2) % vic_pkg::lines_per_frame);
    cpu_write(vic_pkg::reg_ctrl, {tgt[8], 7'd0});
    cpu_write(vic_pkg::reg_raster, tgt[7:0]);
    for (int polls = 0; polls < 1000 && data[0] !== 1'b1; polls++) begin
      cpu_read(vic_pkg::reg_irq_status, data);
      check_level(irq, 1'b1, "irq with enable cleared");
    end
    if (data[0] !== 1'b1) abort_run("raster status never set with the enable cleared");
    check_byte(data, 8'h01, "status without enable");
    cpu_write(vic_pkg::reg_irq_status, 8'h01);
    close_test("raster interrupt", errs);
  endtask

  task automatic pixel_color();
    int         errs;
    logic [7:0] bord;
    logic [7:0] back;
    errs = err_cnt;
    back = random_byte();
    bord = random_byte();
    if (bord[3:0] == back[3:0]) bord[3:0] = back[3:0] + 4'd1;  // keep the two apart
    cpu_write(vic_pkg::reg_background, back);
    cpu_write(vic_pkg::reg_border, bord);
    wait_level(SIG_ACTIVE, 1'b1, 2 * frame_clocks);
    check_level(active, window_at(edge_cnt), "active at window start");
    check_level(hsync, cycle_of(edge_cnt) < vic_pkg::hsync_cycles, "hsync in window");
    check_level(vsync, line_of(edge_cnt) < vic_pkg::vsync_lines, "vsync in window");
    @(negedge clk_col4x_pal);               // rgb trails active by a clock
    check_rgb(red, green, blue, back[3:0], "rgb inside window");
    wait_level(SIG_ACTIVE, 1'b0, 2 * clocks_per_line);
    check_level(active, window_at(edge_cnt), "active at window end");
    @(negedge clk_col4x_pal);
    check_rgb(red, green, blue, bord[3:0], "rgb in border");
    close_test("pixel colour", errs);
  endtask

  task automatic raster_read();
    int         errs;
    logic [7:0] data;
    logic [8:0] exp_line;
    errs = err_cnt;
    for (int pass = 0; pass < 2; pass++) begin
      cpu_read(vic_pkg::reg_raster, data);
      exp_line = 9'(line_of(access_edges));
      check_byte(data, exp_line[7:0], "raster register");
      cpu_read(vic_pkg::reg_ctrl, data);
      exp_line = 9'(line_of(access_edges));
      check_level(data[7], exp_line[8], "ctrl bit 7");
      // second pass runs above line 256 so bit 8 is set
      for (int i = 0; i < frame_clocks && line_of(edge_cnt) < 257; i++) begin
        @(negedge clk_col4x_pal);
      end
      if (line_of(edge_cnt) < 257) abort_run("raster never passed line 256");
    end
    close_test("raster read", errs);
  endtask

  initial begin
    rst_n   = 1'b0;
    ce      = 1'b1;
    rw      = 1'b1;
    lp      = 1'b0;
    adl_drv = 6'h00;
    adl_oe  = 1'b0;
    dbl_drv = 8'h00;
    dbl_oe  = 1'b0;
    repeat (8) @(posedge clk_col4x_pal);
    rst_n <= 1'b1;
    reset_state();
    refresh_cycles();
    register_readback();
    raster_irq();
    pixel_color();
    raster_read();
    $display("tests: %0d ok, %0d failing, %0d mismatches", tests_ok, tests_bad, err_cnt);
    if (tests_bad == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: build.f
src/vic_pkg.sv
src/raster_timer.sv
src/bus_sequencer.sv
src/vic_registers.sv
src/pixel_out.sv
src/vic_top.sv
tests/tb_vic_top.sv
